//--- raster_geom_pkg.sv
package raster_geom_pkg;

  localparam int frame_width  = 32;  // pixels per line
  localparam int frame_height = 24;  // lines per frame
  localparam int frame_pixels = frame_width * frame_height;

  localparam int coord_width = 6;   // covers off-frame vertices up to 63
  localparam int edge_width  = 16;  // room for a 63x63 cross product difference

  // unsigned screen coordinate
  typedef logic [coord_width-1:0] coord_t;

  // signed edge function result
  typedef logic signed [edge_width-1:0] edge_t;

  typedef struct packed {
    coord_t x;
    coord_t y;
  } point_t;

  // screen space triangle, winding order is free
  typedef struct packed {
    point_t a;
    point_t b;
    point_t c;
  } triangle_t;

endpackage

//--- fb_pkg.sv
package fb_pkg;

  localparam int color_width   = 12;  // 4 bits per channel
  localparam int chan_width    = 4;
  localparam int pixel_width   = 16;  // one framebuffer memory word
  localparam int block_pixels  = 8;   // pixels per block write
  localparam int fb_addr_width = 10;

  localparam logic [color_width-1:0] bg_color = 12'h000;

  typedef logic [$clog2(block_pixels)-1:0] blk_idx_t;
  typedef logic [fb_addr_width-1:0] fb_addr_t;

  // same word seen as raw memory data or as colour channels
  typedef union packed {
    logic [pixel_width-1:0] raw;
    struct packed {
      logic [pixel_width-color_width-1:0] pad;  // always zero
      logic [chan_width-1:0] r;
      logic [chan_width-1:0] g;
      logic [chan_width-1:0] b;
    } ch;
  } pixel_t;

  typedef pixel_t [block_pixels-1:0] block_t;  // pixel 0 in the lsbs

  typedef struct packed {
    pixel_t   pixel;
    fb_addr_t addr;
  } pix_beat_t;

  typedef struct packed {
    fb_addr_t addr;  // address of pixel 0
    block_t   data;
  } blk_write_t;

endpackage

//--- tri_coverage_scan.sv
module tri_coverage_scan (
  input  logic                            sys_clk,
  input  logic                            sys_rst,
  input  logic                            start,
  input  raster_geom_pkg::triangle_t      tri_in,
  input  logic [fb_pkg::color_width-1:0]  fg_color,
  output logic                            busy,
  output logic                            pix_valid,
  output fb_pkg::pix_beat_t               pix
);

  raster_geom_pkg::triangle_t tri_q;
  logic [fb_pkg::color_width-1:0] color_q;

  raster_geom_pkg::coord_t x;
  raster_geom_pkg::coord_t y;
  fb_pkg::fb_addr_t        addr;

  raster_geom_pkg::point_t p;
  raster_geom_pkg::edge_t  e_ab;
  raster_geom_pkg::edge_t  e_bc;
  raster_geom_pkg::edge_t  e_ca;
  logic covered;
  logic last_x;
  logic last_px;
  logic accept;

  // (vx-ux)(py-uy) - (vy-uy)(px-ux)
  function automatic raster_geom_pkg::edge_t edge_fn(
    input raster_geom_pkg::point_t u,
    input raster_geom_pkg::point_t v,
    input raster_geom_pkg::point_t q
  );
    raster_geom_pkg::edge_t ux;
    raster_geom_pkg::edge_t uy;
    raster_geom_pkg::edge_t vx;
    raster_geom_pkg::edge_t vy;
    raster_geom_pkg::edge_t qx;
    raster_geom_pkg::edge_t qy;
    ux = u.x;  // zero extended
    uy = u.y;
    vx = v.x;
    vy = v.y;
    qx = q.x;
    qy = q.y;
    return (vx - ux) * (qy - uy) - (vy - uy) * (qx - ux);
  endfunction

  assign accept  = start && !busy;
  assign last_x  = (x == raster_geom_pkg::coord_t'(raster_geom_pkg::frame_width - 1));
  assign last_px = last_x && (y == raster_geom_pkg::coord_t'(raster_geom_pkg::frame_height - 1));

  assign p.x  = x;
  assign p.y  = y;
  assign e_ab = edge_fn(tri_q.a, tri_q.b, p);
  assign e_bc = edge_fn(tri_q.b, tri_q.c, p);
  assign e_ca = edge_fn(tri_q.c, tri_q.a, p);

  // inside for either winding, edges count as inside
  assign covered = (e_ab >= 0 && e_bc >= 0 && e_ca >= 0) ||
                   (e_ab <= 0 && e_bc <= 0 && e_ca <= 0);

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      busy      <= 1'b0;
      pix_valid <= 1'b0;
      x         <= '0;
      y         <= '0;
      addr      <= '0;
    end else begin
      pix_valid <= busy;  // one beat per sweep cycle
      if (accept) begin
        busy <= 1'b1;
        x    <= '0;
        y    <= '0;
        addr <= '0;
      end else if (busy) begin
        addr <= addr + 1'b1;
        if (last_px) begin
          busy <= 1'b0;  // drops as the last beat goes out
          x    <= '0;
          y    <= '0;
        end else if (last_x) begin
          x <= '0;
          y <= y + 1'b1;
        end else begin
          x <= x + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (accept) begin
      tri_q   <= tri_in;
      color_q <= fg_color;
    end
    pix.addr      <= addr;
    pix.pixel.raw <= {{(fb_pkg::pixel_width - fb_pkg::color_width){1'b0}},
                      covered ? color_q : fb_pkg::bg_color};
  end

endmodule

//--- pixel_block_packer.sv
module pixel_block_packer (
  input  logic               sys_clk,
  input  logic               sys_rst,
  input  logic               pix_valid,
  input  fb_pkg::pix_beat_t  pix,
  output logic               blk_wr,
  output fb_pkg::blk_write_t blk
);

  // pixels 0..6 of the block being gathered
  fb_pkg::pixel_t [fb_pkg::block_pixels-2:0] pend;
  fb_pkg::fb_addr_t start_q;
  fb_pkg::blk_idx_t idx;
  logic             last_idx;

  assign idx      = fb_pkg::blk_idx_t'(pix.addr);  // low address bits
  assign last_idx = (idx == fb_pkg::blk_idx_t'(fb_pkg::block_pixels - 1));

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      blk_wr <= 1'b0;
    end else begin
      blk_wr <= pix_valid && last_idx;  // single cycle strobe
    end
  end

  always_ff @(posedge sys_clk) begin
    if (pix_valid) begin
      if (idx == '0) begin
        start_q <= pix.addr;  // first pixel fixes the block address
      end
      if (last_idx) begin
        blk.addr <= start_q;
        // final pixel goes straight in, no extra cycle
        blk.data <= {pix.pixel.raw, pend};
      end else begin
        pend[idx].raw <= pix.pixel.raw;
      end
    end
  end

endmodule

//--- scanout_unpacker.sv
module scanout_unpacker (
  input  logic                           sys_clk,
  input  logic                           sys_rst,
  input  logic                           blk_wr,
  input  fb_pkg::blk_write_t             blk,
  output logic                           out_valid,
  output fb_pkg::fb_addr_t               out_addr,
  output logic [fb_pkg::chan_width-1:0]  out_r,
  output logic [fb_pkg::chan_width-1:0]  out_g,
  output logic [fb_pkg::chan_width-1:0]  out_b
);

  fb_pkg::block_t   bank      [2];
  fb_pkg::fb_addr_t bank_addr [2];

  logic             wr_sel;  // bank taking the next block
  logic             rd_sel;  // bank being replayed
  fb_pkg::blk_idx_t rd_idx;
  fb_pkg::pixel_t   cur;

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      wr_sel    <= 1'b0;
      rd_sel    <= 1'b0;
      rd_idx    <= '0;
      out_valid <= 1'b0;
    end else if (blk_wr) begin
      wr_sel    <= ~wr_sel;
      rd_sel    <= wr_sel;  // replay the block just stored
      rd_idx    <= '0;
      out_valid <= 1'b1;
    end else if (out_valid) begin
      rd_idx <= rd_idx + 1'b1;
      if (rd_idx == fb_pkg::blk_idx_t'(fb_pkg::block_pixels - 1)) begin
        out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (blk_wr) begin
      bank[wr_sel]      <= blk.data;
      bank_addr[wr_sel] <= blk.addr;
    end
  end

  assign cur      = bank[rd_sel][rd_idx];
  assign out_addr = bank_addr[rd_sel] + fb_pkg::fb_addr_t'(rd_idx);
  assign out_r    = cur.ch.r;  // channel view of the word
  assign out_g    = cur.ch.g;
  assign out_b    = cur.ch.b;

endmodule

//--- raster_top.sv
module raster_top (
  input  logic                           sys_clk,
  input  logic                           sys_rst,
  input  logic                           start,
  input  raster_geom_pkg::triangle_t     tri_in,
  input  logic [fb_pkg::color_width-1:0] fg_color,
  output logic                           busy,
  output logic                           blk_wr,
  output fb_pkg::blk_write_t             blk,
  output logic                           out_valid,
  output fb_pkg::fb_addr_t               out_addr,
  output logic [fb_pkg::chan_width-1:0]  out_r,
  output logic [fb_pkg::chan_width-1:0]  out_g,
  output logic [fb_pkg::chan_width-1:0]  out_b
);

  logic              pix_valid;
  fb_pkg::pix_beat_t pix;

  tri_coverage_scan u_scan (
    .sys_clk   (sys_clk),
    .sys_rst   (sys_rst),
    .start     (start),
    .tri_in    (tri_in),
    .fg_color  (fg_color),
    .busy      (busy),
    .pix_valid (pix_valid),
    .pix       (pix)
  );

  pixel_block_packer u_pack (
    .sys_clk   (sys_clk),
    .sys_rst   (sys_rst),
    .pix_valid (pix_valid),
    .pix       (pix),
    .blk_wr    (blk_wr),
    .blk       (blk)
  );

  // block writes also leave the top for the framebuffer side
  scanout_unpacker u_unpack (
    .sys_clk   (sys_clk),
    .sys_rst   (sys_rst),
    .blk_wr    (blk_wr),
    .blk       (blk),
    .out_valid (out_valid),
    .out_addr  (out_addr),
    .out_r     (out_r),
    .out_g     (out_g),
    .out_b     (out_b)
  );

endmodule

//--- tb_raster_top.sv
module tb_raster_top;

  localparam int num_vectors = 5;
  localparam int watchdog_limit = num_vectors * (raster_geom_pkg::frame_pixels + 40) * 4 + 2000;

  // one frame of stimulus with its expected fill
  typedef struct packed {
    raster_geom_pkg::triangle_t     shape;
    logic [fb_pkg::color_width-1:0] color;
    logic [3:0]                     delay;      // idle cycles before start
    logic                           mid_start;  // second start during the sweep
    logic [1:0]                     fill;       // 0 mixed, 1 all fg, 2 all bg
  } vector_t;

  logic                           sys_clk = 1'b0;
  logic                           sys_rst;
  logic                           start;
  raster_geom_pkg::triangle_t     tri_in;
  logic [fb_pkg::color_width-1:0] fg_color;
  logic                           busy;
  logic                           blk_wr;
  fb_pkg::blk_write_t             blk;
  logic                           out_valid;
  fb_pkg::fb_addr_t               out_addr;
  logic [fb_pkg::chan_width-1:0]  out_r;
  logic [fb_pkg::chan_width-1:0]  out_g;
  logic [fb_pkg::chan_width-1:0]  out_b;

  vector_t vectors [num_vectors];
  logic [fb_pkg::color_width-1:0] exp_frame [raster_geom_pkg::frame_pixels];
  logic [fb_pkg::color_width-1:0] cur_color;
  logic [1:0] cur_fill;
  int blk_cnt;
  int out_cnt;
  int busy_cnt;
  logic prev_out_valid;

  raster_top uut (
    .sys_clk   (sys_clk),
    .sys_rst   (sys_rst),
    .start     (start),
    .tri_in    (tri_in),
    .fg_color  (fg_color),
    .busy      (busy),
    .blk_wr    (blk_wr),
    .blk       (blk),
    .out_valid (out_valid),
    .out_addr  (out_addr),
    .out_r     (out_r),
    .out_g     (out_g),
    .out_b     (out_b)
  );

  initial begin
    forever #2 sys_clk = ~sys_clk;
  end

  task automatic check(input logic [31:0] actual, input logic [31:0] expected, input string msg);
    if (actual !== expected) begin
      $display("ERROR at time %0t: %s (got %0h, expected %0h)", $time, msg, actual, expected);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  endtask

  function automatic raster_geom_pkg::triangle_t make_triangle(
    input int ax, input int ay, input int bx, input int by, input int cx, input int cy
  );
    raster_geom_pkg::triangle_t t;
    t.a.x = raster_geom_pkg::coord_t'(ax);
    t.a.y = raster_geom_pkg::coord_t'(ay);
    t.b.x = raster_geom_pkg::coord_t'(bx);
    t.b.y = raster_geom_pkg::coord_t'(by);
    t.c.x = raster_geom_pkg::coord_t'(cx);
    t.c.y = raster_geom_pkg::coord_t'(cy);
    return t;
  endfunction

  // edge value for edge u->v at point p
  function automatic int edge_val(input int ux, input int uy, input int vx, input int vy,
                                  input int px, input int py);
    return (vx - ux) * (py - uy) - (vy - uy) * (px - ux);
  endfunction

  function automatic logic [fb_pkg::color_width-1:0] expected_color(
    input raster_geom_pkg::triangle_t t, input logic [fb_pkg::color_width-1:0] fg, input int k
  );
    int px;
    int py;
    int e0;
    int e1;
    int e2;
    px = k % raster_geom_pkg::frame_width;
    py = k / raster_geom_pkg::frame_width;
    e0 = edge_val(int'(t.a.x), int'(t.a.y), int'(t.b.x), int'(t.b.y), px, py);
    e1 = edge_val(int'(t.b.x), int'(t.b.y), int'(t.c.x), int'(t.c.y), px, py);
    e2 = edge_val(int'(t.c.x), int'(t.c.y), int'(t.a.x), int'(t.a.y), px, py);
    if ((e0 >= 0 && e1 >= 0 && e2 >= 0) || (e0 <= 0 && e1 <= 0 && e2 <= 0))
      return fg;
    return fb_pkg::bg_color;
  endfunction

  always @(negedge sys_clk) begin
    if (sys_rst) begin
      check(busy, 0, "busy high during reset");
      check(blk_wr, 0, "blk_wr high during reset");
      check(out_valid, 0, "out_valid high during reset");
    end else begin
      if (busy)
        busy_cnt++;
      if (blk_wr) begin
        check(blk_cnt < 96, 1, "extra block write in frame");
        check(blk.addr, blk_cnt * fb_pkg::block_pixels, "block start address");
        for (int i = 0; i < fb_pkg::block_pixels; i++)
          check(blk.data[i].raw, {4'h0, exp_frame[blk_cnt * fb_pkg::block_pixels + i]},
                "block pixel word");
        blk_cnt++;
      end
      if (out_valid) begin
        check(out_cnt < raster_geom_pkg::frame_pixels, 1, "extra scanout beat in frame");
        check(out_addr, out_cnt, "scanout address");
        if (out_cnt % fb_pkg::block_pixels != 0)
          check(prev_out_valid, 1, "gap inside a scanout block");
        check({out_r, out_g, out_b}, exp_frame[out_cnt], "scanout colour");
        if (cur_fill == 2'd1)
          check({out_r, out_g, out_b}, cur_color, "full triangle pixel not foreground");
        if (cur_fill == 2'd2)
          check({out_r, out_g, out_b}, fb_pkg::bg_color, "off-frame pixel not background");
        out_cnt++;
      end
      prev_out_valid = out_valid;
    end
  end

  initial begin
    #(watchdog_limit);
    $display("simulation timed out before all frames finished");
    $display("TESTBENCH FAILED");
    $fatal(1);
  end

  initial begin
    void'($urandom(69));
    sys_rst        = 1'b1;
    start          = 1'b0;
    tri_in         = '0;
    fg_color       = '0;
    blk_cnt        = 0;
    out_cnt        = 0;
    busy_cnt       = 0;
    cur_color      = '0;
    cur_fill       = '0;
    prev_out_valid = 1'b0;

    vectors[0] = {make_triangle(2, 2, 28, 5, 10, 20), 12'hf80, 4'd3, 1'b0, 2'd0};   // clockwise
    vectors[1] = {make_triangle(5, 3, 8, 22, 30, 12), 12'h0af, 4'd1, 1'b1, 2'd0};   // ccw
    vectors[2] = {make_triangle(0, 0, 63, 0, 0, 63), 12'h5c3, 4'd0, 1'b0, 2'd1};    // whole frame
    vectors[3] = {make_triangle(4, 3, 12, 9, 28, 21), 12'hfff, 4'd2, 1'b0, 2'd0};   // a line
    vectors[4] = {make_triangle(40, 30, 63, 30, 50, 63), 12'h777, 4'd5, 1'b0, 2'd2}; // off frame

    repeat (3) @(posedge sys_clk);
    #1 sys_rst = 1'b0;
    @(negedge sys_clk);
    check(busy, 0, "busy after reset");
    check(blk_wr, 0, "blk_wr after reset");
    check(out_valid, 0, "out_valid after reset");

    for (int v = 0; v < num_vectors; v++) begin
      repeat (vectors[v].delay + $urandom % 6) @(posedge sys_clk);
      for (int k = 0; k < raster_geom_pkg::frame_pixels; k++)
        exp_frame[k] = expected_color(vectors[v].shape, vectors[v].color, k);
      cur_color = vectors[v].color;
      cur_fill  = vectors[v].fill;
      blk_cnt   = 0;
      out_cnt   = 0;
      busy_cnt  = 0;

      @(posedge sys_clk);
      #1;
      start    = 1'b1;
      tri_in   = vectors[v].shape;
      fg_color = vectors[v].color;
      @(negedge sys_clk);
      check(busy, 0, "busy before start accepted");
      @(posedge sys_clk);
      #1;
      start    = 1'b0;
      tri_in   = make_triangle(1, 1, 1, 1, 1, 1);  // must not reach the sweep
      fg_color = ~vectors[v].color;
      @(negedge sys_clk);
      check(busy, 1, "busy after accepted start");

      if (vectors[v].mid_start) begin
        repeat (300) @(posedge sys_clk);
        #1;
        start    = 1'b1;
        tri_in   = make_triangle(0, 0, 31, 0, 0, 23);
        fg_color = 12'h00f;
        @(posedge sys_clk);
        #1 start = 1'b0;
      end

      wait (out_cnt == raster_geom_pkg::frame_pixels);
      repeat (3) @(posedge sys_clk);
      check(blk_cnt, 96, "block writes per frame");
      check(busy_cnt, raster_geom_pkg::frame_pixels, "busy cycles per frame");
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- build.f
raster_geom_pkg.sv
fb_pkg.sv
tri_coverage_scan.sv
pixel_block_packer.sv
scanout_unpacker.sv
raster_top.sv
tb_raster_top.sv

//--- Bender.yml
package:
  name: raster_top

sources:
  - raster_geom_pkg.sv
  - fb_pkg.sv
  - tri_coverage_scan.sv
  - pixel_block_packer.sv
  - scanout_unpacker.sv
  - raster_top.sv
  - target: test
    files:
      - tb_raster_top.sv
